// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    // Machine widths
    localparam int XLEN     = 64;
    localparam int ILEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = 5;
    localparam int PC_STEP  = 4;

    // Controller phases, every instruction walks FETCH to COMPLETE
    typedef enum logic [2:0] {
        PREPARE,
        FETCH,
        LOAD_IR,
        EXEC,
        COMPLETE,
        HALT
    } ctrl_state_e;

    // Decoded instruction
    typedef enum logic [3:0] {
        OP_ADD,
        OP_ADDI,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_LUI,
        OP_LD,
        OP_SD,
        OP_BEQ,
        OP_JAL,
        OP_ILLEGAL
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic {
        OP2_REG,
        OP2_IMM
    } op2_sel_e;

    // Register writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JUMP
    } pc_sel_e;

    typedef struct packed {
        op_e               op;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   imm;
    } decoded_t;

    typedef struct packed {
        alu_op_e  alu_op;
        op2_sel_e op2_sel;
        logic     reg_we;
        wb_sel_e  wb_sel;
        logic     pc_en;
        pc_sel_e  pc_sel;
    } datapath_ctrl_t;

    // Single memory port, read data comes back one cycle later
    typedef struct packed {
        logic            cs;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

endpackage

// ==== datapath/alu.sv ====
module alu (
    input  cpu_pkg::datapath_ctrl_t  ctrl,
    input  cpu_pkg::decoded_t        dec,
    input  logic [cpu_pkg::XLEN-1:0] rs1_data,
    input  logic [cpu_pkg::XLEN-1:0] rs2_data,
    output logic [cpu_pkg::XLEN-1:0] alu_result,
    output logic                     alu_zero
);

    logic [cpu_pkg::XLEN-1:0] op_b;
    logic [5:0]               shamt;

    assign op_b  = (ctrl.op2_sel == cpu_pkg::OP2_IMM) ? dec.imm : rs2_data;
    // Only the low six bits count for 64-bit shifts
    assign shamt = op_b[5:0];

    always_comb begin
        case (ctrl.alu_op)
            cpu_pkg::ALU_ADD:    alu_result = rs1_data + op_b;
            cpu_pkg::ALU_SUB:    alu_result = rs1_data - op_b;
            cpu_pkg::ALU_AND:    alu_result = rs1_data & op_b;
            cpu_pkg::ALU_OR:     alu_result = rs1_data | op_b;
            cpu_pkg::ALU_XOR:    alu_result = rs1_data ^ op_b;
            cpu_pkg::ALU_SLL:    alu_result = rs1_data << shamt;
            cpu_pkg::ALU_SRL:    alu_result = rs1_data >> shamt;
            cpu_pkg::ALU_PASS_B: alu_result = op_b;
            default:             alu_result = '0;
        endcase
    end

    // Equal operands for BEQ
    assign alu_zero = (alu_result == '0);

endmodule

// ==== datapath/reg_file.sv ====
module reg_file (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_pkg::datapath_ctrl_t  ctrl,
    input  cpu_pkg::decoded_t        dec,
    input  logic [cpu_pkg::XLEN-1:0] alu_result,
    input  logic [cpu_pkg::XLEN-1:0] mem_rdata,
    input  logic [cpu_pkg::XLEN-1:0] pc,
    output logic [cpu_pkg::XLEN-1:0] rs1_data,
    output logic [cpu_pkg::XLEN-1:0] rs2_data
);

    logic [cpu_pkg::NUM_REGS-1:0][cpu_pkg::XLEN-1:0] regs;
    logic [cpu_pkg::XLEN-1:0]                        wb_data;

    always_comb begin
        case (ctrl.wb_sel)
            cpu_pkg::WB_MEM: wb_data = mem_rdata;
            cpu_pkg::WB_PC4: wb_data = pc + cpu_pkg::PC_STEP;
            default:         wb_data = alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '0;
        end else if (ctrl.reg_we && dec.rd != '0) begin
            regs[dec.rd] <= wb_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// ==== datapath/pc_unit.sv ====
module pc_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_pkg::datapath_ctrl_t  ctrl,
    input  logic [cpu_pkg::XLEN-1:0] imm,
    input  logic                     alu_zero,
    output logic [cpu_pkg::XLEN-1:0] pc
);

    logic [cpu_pkg::XLEN-1:0] pc_seq;
    logic [cpu_pkg::XLEN-1:0] pc_target;
    logic [cpu_pkg::XLEN-1:0] pc_next;

    assign pc_seq    = pc + cpu_pkg::PC_STEP;
    assign pc_target = pc + imm;

    always_comb begin
        case (ctrl.pc_sel)
            cpu_pkg::PC_JUMP:   pc_next = pc_target;
            cpu_pkg::PC_BRANCH: pc_next = alu_zero ? pc_target : pc_seq;
            default:            pc_next = pc_seq;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (ctrl.pc_en) begin
            pc <= pc_next;
        end
    end

endmodule

// ==== control/instr_decoder.sv ====
module instr_decoder (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     ir_load,
    input  logic [cpu_pkg::XLEN-1:0] mem_rdata,
    output cpu_pkg::decoded_t        dec
);

    logic [cpu_pkg::ILEN-1:0] ir;
    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;

    // Instruction register, cleared to an illegal word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= mem_rdata[cpu_pkg::ILEN-1:0];
        end
    end

    assign opcode  = ir[6:0];
    assign funct3  = ir[14:12];
    assign funct7  = ir[31:25];
    assign dec.rs1 = ir[19:15];
    assign dec.rs2 = ir[24:20];
    assign dec.rd  = ir[11:7];

    always_comb begin
        dec.op = cpu_pkg::OP_ILLEGAL;
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  dec.op = cpu_pkg::OP_ADD;
                        3'b001:  dec.op = cpu_pkg::OP_SLL;
                        3'b100:  dec.op = cpu_pkg::OP_XOR;
                        3'b101:  dec.op = cpu_pkg::OP_SRL;
                        3'b110:  dec.op = cpu_pkg::OP_OR;
                        3'b111:  dec.op = cpu_pkg::OP_AND;
                        default: dec.op = cpu_pkg::OP_ILLEGAL;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec.op = cpu_pkg::OP_SUB;
                end
            end
            7'b0010011: if (funct3 == 3'b000) dec.op = cpu_pkg::OP_ADDI;
            7'b0000011: if (funct3 == 3'b011) dec.op = cpu_pkg::OP_LD;
            7'b0100011: if (funct3 == 3'b011) dec.op = cpu_pkg::OP_SD;
            7'b1100011: if (funct3 == 3'b000) dec.op = cpu_pkg::OP_BEQ;
            7'b1101111: dec.op = cpu_pkg::OP_JAL;
            7'b0110111: dec.op = cpu_pkg::OP_LUI;
            default:    dec.op = cpu_pkg::OP_ILLEGAL;
        endcase
    end

    // Immediate format follows the op, I-type otherwise
    always_comb begin
        case (dec.op)
            cpu_pkg::OP_SD:  dec.imm = {{52{ir[31]}}, ir[31:25], ir[11:7]};
            cpu_pkg::OP_BEQ: dec.imm = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            cpu_pkg::OP_JAL: dec.imm = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            cpu_pkg::OP_LUI: dec.imm = {{32{ir[31]}}, ir[31:12], 12'b0};
            default:         dec.imm = {{52{ir[31]}}, ir[31:20]};
        endcase
    end

endmodule

// ==== control/ctrl_fsm.sv ====
module ctrl_fsm (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_pkg::decoded_t        dec,
    input  logic [cpu_pkg::XLEN-1:0] pc,
    input  logic [cpu_pkg::XLEN-1:0] alu_result,
    input  logic [cpu_pkg::XLEN-1:0] rs2_data,
    output cpu_pkg::datapath_ctrl_t  ctrl,
    output logic                     ir_load,
    output cpu_pkg::mem_req_t        mem_req,
    output logic                     halted
);

    cpu_pkg::ctrl_state_e state;
    cpu_pkg::ctrl_state_e next_state;
    logic                 writes_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cpu_pkg::PREPARE;
        end else begin
            state <= next_state;
        end
    end

    // An illegal word is caught once the IR holds it
    always_comb begin
        case (state)
            cpu_pkg::PREPARE:  next_state = cpu_pkg::FETCH;
            cpu_pkg::FETCH:    next_state = cpu_pkg::LOAD_IR;
            cpu_pkg::LOAD_IR:  next_state = cpu_pkg::EXEC;
            cpu_pkg::EXEC:     next_state = (dec.op == cpu_pkg::OP_ILLEGAL) ?
                                            cpu_pkg::HALT : cpu_pkg::COMPLETE;
            cpu_pkg::COMPLETE: next_state = cpu_pkg::FETCH;
            default:           next_state = cpu_pkg::HALT;
        endcase
    end

    // Per-opcode datapath selections, held stable across EXEC and COMPLETE
    always_comb begin
        ctrl.alu_op  = cpu_pkg::ALU_ADD;
        ctrl.op2_sel = cpu_pkg::OP2_REG;
        ctrl.wb_sel  = cpu_pkg::WB_ALU;
        ctrl.pc_sel  = cpu_pkg::PC_SEQ;
        writes_rd    = 1'b1;
        case (dec.op)
            cpu_pkg::OP_ADDI: ctrl.op2_sel = cpu_pkg::OP2_IMM;
            cpu_pkg::OP_SUB:  ctrl.alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
            cpu_pkg::OP_XOR:  ctrl.alu_op = cpu_pkg::ALU_XOR;
            cpu_pkg::OP_SLL:  ctrl.alu_op = cpu_pkg::ALU_SLL;
            cpu_pkg::OP_SRL:  ctrl.alu_op = cpu_pkg::ALU_SRL;
            cpu_pkg::OP_LUI: begin
                ctrl.alu_op  = cpu_pkg::ALU_PASS_B;
                ctrl.op2_sel = cpu_pkg::OP2_IMM;
            end
            cpu_pkg::OP_LD: begin
                ctrl.op2_sel = cpu_pkg::OP2_IMM;
                ctrl.wb_sel  = cpu_pkg::WB_MEM;
            end
            cpu_pkg::OP_SD: begin
                ctrl.op2_sel = cpu_pkg::OP2_IMM;
                writes_rd    = 1'b0;
            end
            cpu_pkg::OP_BEQ: begin
                // Equality test through the subtractor
                ctrl.alu_op = cpu_pkg::ALU_SUB;
                ctrl.pc_sel = cpu_pkg::PC_BRANCH;
                writes_rd   = 1'b0;
            end
            cpu_pkg::OP_JAL: begin
                ctrl.wb_sel = cpu_pkg::WB_PC4;
                ctrl.pc_sel = cpu_pkg::PC_JUMP;
            end
            cpu_pkg::OP_ILLEGAL: writes_rd = 1'b0;
            default: ctrl.alu_op = cpu_pkg::ALU_ADD;
        endcase
        ctrl.reg_we = (state == cpu_pkg::COMPLETE) && writes_rd;
        ctrl.pc_en  = (state == cpu_pkg::COMPLETE);
    end

    // Fetch in FETCH, data access in EXEC
    always_comb begin
        mem_req.cs    = 1'b0;
        mem_req.we    = 1'b0;
        mem_req.addr  = pc;
        mem_req.wdata = rs2_data;
        if (state == cpu_pkg::FETCH) begin
            mem_req.cs = 1'b1;
        end else if (state == cpu_pkg::EXEC) begin
            mem_req.addr = alu_result;
            mem_req.cs   = (dec.op == cpu_pkg::OP_LD) || (dec.op == cpu_pkg::OP_SD);
            mem_req.we   = (dec.op == cpu_pkg::OP_SD);
        end
    end

    assign ir_load = (state == cpu_pkg::LOAD_IR);
    assign halted  = (state == cpu_pkg::HALT);

endmodule

// ==== design/cpu_top.sv ====
module cpu_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [cpu_pkg::XLEN-1:0] mem_rdata,
    output cpu_pkg::mem_req_t        mem_req,
    output logic                     halted
);

    cpu_pkg::decoded_t       dec;
    cpu_pkg::datapath_ctrl_t ctrl;
    logic                    ir_load;
    logic [cpu_pkg::XLEN-1:0] rs1_data;
    logic [cpu_pkg::XLEN-1:0] rs2_data;
    logic [cpu_pkg::XLEN-1:0] alu_result;
    logic                    alu_zero;
    logic [cpu_pkg::XLEN-1:0] pc;

    ctrl_fsm u_ctrl_fsm (
        .clk        (clk),
        .arst_n     (arst_n),
        .dec        (dec),
        .pc         (pc),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .ctrl       (ctrl),
        .ir_load    (ir_load),
        .mem_req    (mem_req),
        .halted     (halted)
    );

    instr_decoder u_instr_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .ir_load   (ir_load),
        .mem_rdata (mem_rdata),
        .dec       (dec)
    );

    alu u_alu (
        .ctrl       (ctrl),
        .dec        (dec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .alu_zero   (alu_zero)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .dec        (dec),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    pc_unit u_pc_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .imm      (dec.imm),
        .alu_zero (alu_zero),
        .pc       (pc)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam real HALF_PERIOD_NS = 2.0;
    localparam int  RESET_CYCLES   = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Release lines up with a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== test/cpu_top_assert.sv ====
module cpu_top_assert (
    input logic              clk,
    input logic              arst_n,
    input cpu_pkg::mem_req_t mem_req,
    input logic              halted
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed properties so far
    int error_count = 0;

    // A write is always a selected access
    we_needs_cs: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.we |-> mem_req.cs)
        else begin
            error_count++;
            $error("write enable without chip select");
        end

    // Memory port stays quiet once halted
    quiet_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !mem_req.cs)
        else begin
            error_count++;
            $error("memory request while halted");
        end

    // Fetch or data strobe is one cycle wide and never back to back
    cs_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(mem_req.cs) |=> !mem_req.cs ##2 !mem_req.cs)
        else begin
            error_count++;
            $error("chip select outside the four-cycle rhythm");
        end

    // Next request at most four cycles later unless the core halts
    cs_rhythm: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.cs |-> ##[1:4] (mem_req.cs || halted))
        else begin
            error_count++;
            $error("gap between memory requests longer than four cycles");
        end

endmodule

bind cpu_top cpu_top_assert u_cpu_top_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .mem_req (mem_req),
    .halted  (halted)
);

// ==== test/tb_cpu_top.sv ====
module tb_cpu_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN       = 60;
    localparam int END_ADDR       = PROG_LEN * 4;
    localparam int DATA_BASE      = 'h400;
    localparam int DATA_WORDS     = 32;
    localparam int TIMEOUT_CYCLES = 16 + 1 + (PROG_LEN + 1) * 4 + 64;

    logic              clk;
    logic              arst_n;
    logic [63:0]       mem_rdata;
    cpu_pkg::mem_req_t mem_req;
    logic              halted;

    logic [63:0]  mem [logic [63:0]];
    logic [63:0]  model_mem [logic [63:0]];
    logic [31:0]  lfsr_state;
    cpu_pkg::op_e prog_op [PROG_LEN];
    logic [4:0]   prog_rd [PROG_LEN];
    logic [4:0]   prog_rs1 [PROG_LEN];
    logic [4:0]   prog_rs2 [PROG_LEN];
    logic [63:0]  prog_imm [PROG_LEN];
    // Expected traffic; stores carry {rs2 is x0, addr, data}
    logic [63:0]  fetch_q [$];
    logic [63:0]  load_q [$];
    logic [128:0] store_q [$];
    logic [128:0] exp_store;
    logic [63:0]  exp_addr;
    int           executed;
    int           fetch_count = 0;
    int           last_fetch = 0;
    int           cycle = 0;
    int           timeout_count = 0;
    bit           halt_seen = 1'b0;

    tb_clock_gen u_clock_gen (.clk(clk), .arst_n(arst_n));

    cpu_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .halted    (halted)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            bits = {bits[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // RV64 base encodings
    function automatic logic [31:0] encode(input cpu_pkg::op_e op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [63:0] imm);
        case (op)
            cpu_pkg::OP_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            cpu_pkg::OP_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            cpu_pkg::OP_SLL:  return {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
            cpu_pkg::OP_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            cpu_pkg::OP_SRL:  return {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0110011};
            cpu_pkg::OP_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            cpu_pkg::OP_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            cpu_pkg::OP_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            cpu_pkg::OP_LD:   return {imm[11:0], rs1, 3'b011, rd, 7'b0000011};
            cpu_pkg::OP_SD:   return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
            cpu_pkg::OP_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                                      7'b1100011};
            cpu_pkg::OP_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            cpu_pkg::OP_LUI:  return {imm[31:12], rd, 7'b0110111};
            default:          return '0;
        endcase
    endfunction

    task automatic build_program();
        logic [63:0] word;
        int          k;
        for (int i = 0; i < DATA_WORDS; i++) begin
            word = take_bits(64);
            mem[DATA_BASE + 8 * i] = word;
            model_mem[DATA_BASE + 8 * i] = word;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            // Codes 13 to 15 fold into extra stores
            word        = take_bits(4);
            prog_op[i]  = (word >= 13) ? cpu_pkg::OP_SD : cpu_pkg::op_e'(word[3:0]);
            prog_rd[i]  = take_bits(3);
            prog_rs1[i] = take_bits(3);
            prog_rs2[i] = take_bits(3);
            prog_imm[i] = '0;
            case (prog_op[i])
                cpu_pkg::OP_ADDI: begin
                    word = take_bits(12);
                    prog_imm[i] = {{52{word[11]}}, word[11:0]};
                end
                cpu_pkg::OP_LUI: begin
                    word = take_bits(20);
                    prog_imm[i] = {{32{word[19]}}, word[19:0], 12'b0};
                end
                cpu_pkg::OP_LD, cpu_pkg::OP_SD: begin
                    prog_rs1[i] = '0;
                    prog_imm[i] = DATA_BASE + 8 * take_bits(5);
                end
                cpu_pkg::OP_BEQ, cpu_pkg::OP_JAL: begin
                    // Forward only and at most up to the final word
                    k = 1 + take_bits(3);
                    if (i + k > PROG_LEN) k = PROG_LEN - i;
                    prog_imm[i] = 4 * k;
                end
                default: prog_imm[i] = '0;
            endcase
            mem[4 * i] = encode(prog_op[i], prog_rd[i], prog_rs1[i], prog_rs2[i], prog_imm[i]);
        end
        mem[END_ADDR] = '0;
    endtask

    // Instruction-set model over the generated fields
    task automatic run_model();
        logic [63:0] x [32];
        logic [63:0] pc;
        logic [63:0] npc;
        logic [63:0] a;
        logic [63:0] b;
        int          i;
        x = '{default: '0};
        pc = '0;
        executed = 0;
        while (pc != END_ADDR) begin
            i = pc / 4;
            a = x[prog_rs1[i]];
            b = x[prog_rs2[i]];
            npc = pc + 4;
            fetch_q.push_back(pc);
            case (prog_op[i])
                cpu_pkg::OP_ADD:  x[prog_rd[i]] = a + b;
                cpu_pkg::OP_SUB:  x[prog_rd[i]] = a - b;
                cpu_pkg::OP_AND:  x[prog_rd[i]] = a & b;
                cpu_pkg::OP_OR:   x[prog_rd[i]] = a | b;
                cpu_pkg::OP_XOR:  x[prog_rd[i]] = a ^ b;
                cpu_pkg::OP_SLL:  x[prog_rd[i]] = a << b[5:0];
                cpu_pkg::OP_SRL:  x[prog_rd[i]] = a >> b[5:0];
                cpu_pkg::OP_ADDI: x[prog_rd[i]] = a + prog_imm[i];
                cpu_pkg::OP_LUI:  x[prog_rd[i]] = prog_imm[i];
                cpu_pkg::OP_LD: begin
                    load_q.push_back(a + prog_imm[i]);
                    x[prog_rd[i]] = model_mem[a + prog_imm[i]];
                end
                cpu_pkg::OP_SD: begin
                    store_q.push_back({prog_rs2[i] == 5'd0, a + prog_imm[i], b});
                    model_mem[a + prog_imm[i]] = b;
                end
                cpu_pkg::OP_BEQ: if (a == b) npc = pc + prog_imm[i];
                cpu_pkg::OP_JAL: begin
                    x[prog_rd[i]] = pc + 4;
                    npc = pc + prog_imm[i];
                end
                default: npc = pc + 4;
            endcase
            x[0] = '0;
            pc = npc;
            executed++;
        end
        fetch_q.push_back(pc);
    endtask

    // Memory model with one-cycle read latency
    always @(posedge clk) begin
        if (mem_req.cs && mem_req.we) begin
            mem[mem_req.addr] = mem_req.wdata;
        end else if (mem_req.cs) begin
            mem_rdata <= mem.exists(mem_req.addr) ? mem[mem_req.addr] : 64'd0;
        end
    end

    // Port monitor sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            cycle++;
            if (UUT.u_cpu_top_assert.error_count != 0) begin
                report_failure("A bound assertion on the memory port failed");
            end
            if (halted && !halt_seen) begin
                halt_seen = 1'b1;
                check_value("halt latency", 3, cycle - last_fetch);
                check_value("fetch count", executed + 1, fetch_count);
            end
            if (mem_req.cs && halt_seen) begin
                report_failure("A memory request appeared after the processor halted");
            end else if (mem_req.cs && fetch_count > 0 && cycle == last_fetch + 2) begin
                // Data access two cycles after its fetch
                if (mem_req.we && store_q.size() == 0) begin
                    report_failure("The processor wrote memory when no store was expected");
                end else if (mem_req.we) begin
                    exp_store = store_q.pop_front();
                    check_value("store address", exp_store[127:64], mem_req.addr);
                    check_value(exp_store[128] ? "x0 store data" : "store data",
                                exp_store[63:0], mem_req.wdata);
                end else if (load_q.size() == 0) begin
                    report_failure("The processor read data when no load was expected");
                end else begin
                    exp_addr = load_q.pop_front();
                    check_value("load address", exp_addr, mem_req.addr);
                end
            end else if (mem_req.cs && fetch_q.size() == 0) begin
                report_failure("The processor fetched past the final instruction");
            end else if (mem_req.cs) begin
                if (fetch_count > 0) begin
                    check_value("fetch spacing", 4, cycle - last_fetch);
                end
                exp_addr = fetch_q.pop_front();
                check_value("fetch address", exp_addr, mem_req.addr);
                check_value("fetch write enable", 0, mem_req.we);
                fetch_count++;
                last_fetch = cycle;
            end
        end
    end

    always @(posedge clk) begin
        timeout_count++;
        if (timeout_count >= TIMEOUT_CYCLES) begin
            report_failure("Timeout because the processor did not finish the program in time");
        end
    end

    initial begin
        mem_rdata  = '0;
        lfsr_state = 32'hc488;
        build_program();
        run_model();
        wait (halt_seen);
        // Watch the port a while longer for stray requests
        repeat (16) @(negedge clk);
        check_value("stores left over", 0, store_q.size());
        check_value("loads left over", 0, load_q.size());
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== cpu_top.f ====
common/cpu_pkg.sv
datapath/alu.sv
datapath/reg_file.sv
datapath/pc_unit.sv
control/instr_decoder.sv
control/ctrl_fsm.sv
design/cpu_top.sv
test/tb_clock_gen.sv
test/cpu_top_assert.sv
test/tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - files:
      - common/cpu_pkg.sv
      - datapath/alu.sv
      - datapath/reg_file.sv
      - datapath/pc_unit.sv
      - control/instr_decoder.sv
      - control/ctrl_fsm.sv
      - design/cpu_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/cpu_top_assert.sv
      - test/tb_cpu_top.sv
